// File: flist.f
design/memoredf_pkg.sv
design/config_regs.sv
design/core_queues.sv
design/deadline_timers.sv
design/issue_fsm.sv
design/memoredf_top.sv
dv/memoredf_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the memoredf testbench with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module memoredf_tb -f flist.f -o memoredf_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/memoredf_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

// File: dv/memoredf_tb.sv
`timescale 1ns/1ps

module memoredf_tb;

    localparam int NQ    = 4;
    localparam int DEPTH = 8;
    localparam int DW    = 32;

    logic                    aclk;
    logic                    arst_n;
    logic                    pkt_valid;
    logic [1:0]              pkt_core;
    logic [DW-1:0]           pkt_data;
    logic                    stall;
    logic                    cfg_valid;
    logic [3:0]              cfg_addr;
    memoredf_pkg::cfg_word_u cfg_data;
    logic                    issue_valid;
    logic [1:0]              issue_core;
    logic [DW-1:0]           issue_data;
    logic                    pkt_consumed;

    // scoreboard with one expected queue per core
    logic [DW-1:0] exp_q [NQ][$];
    int            wr_reload [NQ];
    int            issue_reload [NQ];
    int            dl_val [NQ];
    int            cyc;
    int            pushed;
    int            issued;
    int            err_cnt;
    int            to_cnt;
    logic          edf_check;
    logic          tdma_check;
    logic          consume_en;
    logic          pend;
    int            cdelay;
    int            last_core;
    logic          have_last;
    logic          tdma_broken;

    memoredf_top #(
        .NUM_QUEUES (NQ),
        .QUEUE_DEPTH(DEPTH),
        .DATA_WIDTH (DW)
    ) u_dut (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .pkt_valid   (pkt_valid),
        .pkt_core    (pkt_core),
        .pkt_data    (pkt_data),
        .stall       (stall),
        .cfg_valid   (cfg_valid),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .issue_valid (issue_valid),
        .issue_core  (issue_core),
        .issue_data  (issue_data),
        .pkt_consumed(pkt_consumed)
    );

    always #5 aclk = ~aclk;

    //////////////////////////////
    // reference and checks
    //////////////////////////////

    // edf picks the earliest absolute deadline among non-empty queues
    // lowest index wins ties
    // tdma expects the next owner in rotation
    function automatic int sched_pick(input logic [NQ-1:0] nonempty, input logic mode,
                                      input int absdl [NQ], input int tdma_next);
        int best;
        best = -1;
        if (mode) begin
            return tdma_next;
        end
        for (int i = 0; i < NQ; i++) begin
            if (nonempty[i] && (best < 0 || absdl[i] < absdl[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic check_eq(input logic [DW-1:0] act, input logic [DW-1:0] exp,
                            input string msg);
        if (act !== exp) begin
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, msg, act, exp);
            err_cnt++;
        end
    endtask

    // compare every issue against the model
    always @(posedge aclk) begin
        int            c;
        logic [NQ-1:0] ne;
        int            absdl [NQ];
        logic [DW-1:0] d;
        cyc <= cyc + 1;
        if (arst_n && issue_valid) begin
            c = int'(issue_core);
            for (int i = 0; i < NQ; i++) begin
                ne[i]    = (exp_q[i].size() != 0);
                // last reload by write or by service
                absdl[i] = ((wr_reload[i] > issue_reload[i]) ? wr_reload[i] : issue_reload[i])
                           + dl_val[i];
            end
            if (edf_check) begin
                check_eq(DW'(c), DW'(sched_pick(ne, 1'b0, absdl, 0)), "edf pick");
            end
            if (tdma_check && !tdma_broken) begin
                // an empty queue leaves an idle slot
                // rotation check ends there
                if (ne != '1) begin
                    tdma_broken = 1'b1;
                end else if (have_last && c != last_core) begin
                    check_eq(DW'(c), DW'(sched_pick(ne, 1'b1, absdl, (last_core + 1) % NQ)),
                             "tdma rotation");
                end
                last_core = c;
                have_last = 1'b1;
            end
            if (exp_q[c].size() == 0) begin
                $display("[FAIL] %0t: issue from core %0d with nothing pushed", $time, c);
                err_cnt++;
            end else begin
                d = exp_q[c].pop_front();
                check_eq(issue_data, d, "packet data in push order");
            end
            issue_reload[c] = cyc;
            issued++;
        end
    end

    // serializer model consumes after a random delay
    always @(posedge aclk) begin
        pkt_consumed <= 1'b0;
        if (issue_valid) begin
            pend   <= 1'b1;
            cdelay <= $urandom_range(0, 4);
        end else if (pend && consume_en) begin
            if (cdelay == 0) begin
                pkt_consumed <= 1'b1;
                pend         <= 1'b0;
            end else begin
                cdelay <= cdelay - 1;
            end
        end
    end

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic push_pkt(input int core);
        int            t;
        logic [DW-1:0] d;
        t = 0;
        while (stall && t < 300) begin
            @(posedge aclk);
            t++;
        end
        if (t >= 300) begin
            $display("timeout: stall stayed high before a push to core %0d", core);
            to_cnt++;
        end
        d = $urandom;
        pkt_valid <= 1'b1;
        pkt_core  <= 2'(core);
        pkt_data  <= d;
        exp_q[core].push_back(d);
        pushed++;
        @(posedge aclk);
        pkt_valid <= 1'b0;
        // one idle cycle so the registered stall is current
        @(posedge aclk);
    endtask

    task automatic cfg_write(input logic [3:0] addr, input logic [31:0] word);
        cfg_valid <= 1'b1;
        cfg_addr  <= addr;
        cfg_data  <= word;
        // deadline reload lands two edges later
        if (addr >= 4'h8 && addr <= 4'hB) begin
            dl_val[addr - 4'h8]    = int'(word[15:0]);
            wr_reload[addr - 4'h8] = cyc + 2;
        end
        @(posedge aclk);
        cfg_valid <= 1'b0;
        @(posedge aclk);
    endtask

    task automatic wait_drain(input string what);
        int t;
        t = 0;
        while (!(issued == pushed && !pend && !issue_valid) && t < 3000) begin
            @(posedge aclk);
            t++;
        end
        if (t >= 3000) begin
            $display("timeout: queues did not drain during %s", what);
            to_cnt++;
        end
        repeat (3) @(posedge aclk);
    endtask

    task automatic wait_issued(input string what);
        int t;
        t = 0;
        while (issued != pushed && t < 300) begin
            @(posedge aclk);
            t++;
        end
        if (t >= 300) begin
            $display("timeout: last pushed packet was never issued during %s", what);
            to_cnt++;
        end
    endtask

    task automatic wait_stall(input logic level);
        int t;
        t = 0;
        while (stall !== level && t < 100) begin
            @(posedge aclk);
            t++;
        end
        if (t >= 100) begin
            $display("timeout: stall never went to %0b", level);
            to_cnt++;
        end
    endtask

    task automatic fill_all(input int n);
        for (int k = 0; k < n; k++) begin
            for (int i = 0; i < NQ; i++) begin
                push_pkt(i);
            end
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'h939e));
        aclk         = 0;
        arst_n       = 0;
        pkt_valid    = 0;
        pkt_core     = 0;
        pkt_data     = 0;
        pkt_consumed = 0;
        cfg_valid    = 0;
        cfg_addr     = 0;
        cfg_data     = '0;
        cyc          = 0;
        pushed       = 0;
        issued       = 0;
        err_cnt      = 0;
        to_cnt       = 0;
        edf_check    = 0;
        tdma_check   = 0;
        consume_en   = 1;
        pend         = 0;
        cdelay       = 0;
        last_core    = 0;
        have_last    = 0;
        tdma_broken  = 0;
        for (int i = 0; i < NQ; i++) begin
            wr_reload[i]    = 0;
            issue_reload[i] = 0;
            dl_val[i]       = 0;
        end
        repeat (4) @(posedge aclk);
        arst_n <= 1'b1;
        repeat (2) @(posedge aclk);

        // random traffic checks per-core order
        for (int k = 0; k < 40; k++) begin
            push_pkt($urandom_range(0, NQ - 1));
            repeat ($urandom_range(0, 3)) @(posedge aclk);
        end
        wait_drain("random traffic");

        // stall with one packet in flight and core 2 filled
        consume_en = 0;
        push_pkt(1);
        wait_issued("stall setup");
        for (int k = 0; k < DEPTH - 1; k++) begin
            push_pkt(2);
        end
        check_eq(DW'(stall), 0, "stall low below full");
        push_pkt(2);
        wait_stall(1'b1);
        check_eq(DW'(stall), 1, "stall after full queue");
        consume_en = 1;
        wait_stall(1'b0);
        check_eq(DW'(stall), 0, "stall after one pop");
        wait_drain("stall release");

        // edf order with padding above the timer field
        cfg_write(4'h8, 32'hABCD_01F4);
        cfg_write(4'h9, 32'h1234_012C);
        cfg_write(4'hA, 32'hFFFF_0258);
        cfg_write(4'hB, 32'h0F0F_0190);
        cfg_write(4'hC, 32'h0000_0001);
        consume_en = 0;
        fill_all(4);
        edf_check = 1;
        consume_en = 1;
        wait_drain("edf order");
        edf_check = 0;

        // tdma mode from a word that ends in 1
        for (int i = 0; i < NQ; i++) begin
            cfg_write(4'h4 + 4'(i), 32'h0000_0014);
        end
        cfg_write(4'h0, 32'hFFFF_0001);
        cfg_write(4'h3, 32'h0000_0000);
        consume_en = 0;
        fill_all(6);
        tdma_check = 1;
        consume_en = 1;
        wait_drain("tdma rotation");
        tdma_check = 0;

        // the same word as a deadline back in edf mode
        cfg_write(4'h0, 32'hFFFF_FFFE);
        cfg_write(4'hB, 32'hFFFF_0001);
        cfg_write(4'hF, 32'h0000_0001);
        consume_en = 0;
        fill_all(2);
        edf_check = 1;
        consume_en = 1;
        wait_drain("edf after mode change");
        edf_check = 0;

        $display("errors: %0d mismatches, %0d timeouts", err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: design/memoredf_top.sv
`timescale 1ns/1ps

module memoredf_top #(
    parameter  int NUM_QUEUES  = 4,
    parameter  int QUEUE_DEPTH = 8,
    parameter  int DATA_WIDTH  = 32,
    localparam int ID_W        = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
    input  logic                                aclk,
    input  logic                                arst_n,
    // packet intake
    input  logic                                pkt_valid,
    input  logic [ID_W-1:0]                     pkt_core,
    input  logic [DATA_WIDTH-1:0]               pkt_data,
    output logic                                stall,
    // configuration writes
    input  logic                                cfg_valid,
    input  logic [memoredf_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  memoredf_pkg::cfg_word_u             cfg_data,
    // serializer side
    output logic                                issue_valid,
    output logic [ID_W-1:0]                     issue_core,
    output logic [DATA_WIDTH-1:0]               issue_data,
    input  logic                                pkt_consumed
);

    memoredf_pkg::sched_mode_e                        sched_mode;
    logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0] periods;
    logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0] deadlines;
    logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0] deadline_count;
    logic [NUM_QUEUES-1:0]                            cfg_deadline_we;
    logic                                             cfg_mode_we;
    logic [NUM_QUEUES-1:0][DATA_WIDTH-1:0]            head_data;
    logic [NUM_QUEUES-1:0]                            empty;
    logic                                             pop;
    logic [ID_W-1:0]                                  pop_core;
    logic                                             served;
    logic [ID_W-1:0]                                  served_core;
    logic [ID_W-1:0]                                  slot_owner;

    //////////////////////////////
    // configuration
    //////////////////////////////

    config_regs #(
        .NUM_QUEUES(NUM_QUEUES)
    ) u_config_regs (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .sched_mode     (sched_mode),
        .periods        (periods),
        .deadlines      (deadlines),
        .cfg_deadline_we(cfg_deadline_we),
        .cfg_mode_we    (cfg_mode_we)
    );

    //////////////////////////////
    // queues and scheduling
    //////////////////////////////

    core_queues #(
        .NUM_QUEUES (NUM_QUEUES),
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_core_queues (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .pkt_valid(pkt_valid),
        .pkt_core (pkt_core),
        .pkt_data (pkt_data),
        .pop      (pop),
        .pop_core (pop_core),
        .head_data(head_data),
        .empty    (empty),
        .stall    (stall)
    );

    deadline_timers #(
        .NUM_QUEUES(NUM_QUEUES)
    ) u_deadline_timers (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .sched_mode     (sched_mode),
        .periods        (periods),
        .deadlines      (deadlines),
        .cfg_deadline_we(cfg_deadline_we),
        .cfg_mode_we    (cfg_mode_we),
        .served         (served),
        .served_core    (served_core),
        .deadline_count (deadline_count),
        .slot_owner     (slot_owner)
    );

    issue_fsm #(
        .NUM_QUEUES(NUM_QUEUES),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_issue_fsm (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .sched_mode    (sched_mode),
        .empty         (empty),
        .head_data     (head_data),
        .deadline_count(deadline_count),
        .slot_owner    (slot_owner),
        .pkt_consumed  (pkt_consumed),
        .pop           (pop),
        .pop_core      (pop_core),
        .served        (served),
        .served_core   (served_core),
        .issue_valid   (issue_valid),
        .issue_core    (issue_core),
        .issue_data    (issue_data)
    );

endmodule

// File: design/issue_fsm.sv
`timescale 1ns/1ps

module issue_fsm #(
    parameter  int NUM_QUEUES = 4,
    parameter  int DATA_WIDTH = 32,
    localparam int ID_W       = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
    input  logic                                              aclk,
    input  logic                                              arst_n,
    input  memoredf_pkg::sched_mode_e                         sched_mode,
    input  logic [NUM_QUEUES-1:0]                             empty,
    input  logic [NUM_QUEUES-1:0][DATA_WIDTH-1:0]             head_data,
    input  logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0]  deadline_count,
    input  logic [ID_W-1:0]                                   slot_owner,
    input  logic                                              pkt_consumed,
    output logic                                              pop,
    output logic [ID_W-1:0]                                   pop_core,
    output logic                                              served,
    output logic [ID_W-1:0]                                   served_core,
    output logic                                              issue_valid,
    output logic [ID_W-1:0]                                   issue_core,
    output logic [DATA_WIDTH-1:0]                             issue_data
);

    localparam logic [1:0] S_IDLE          = 2'd0;
    localparam logic [1:0] S_ISSUE         = 2'd1;
    localparam logic [1:0] S_WAIT_CONSUMED = 2'd2;

    logic [1:0]                       state;
    logic [1:0]                       state_next;
    logic                             pick_valid;
    logic [ID_W-1:0]                  pick_core;
    logic [memoredf_pkg::TIMER_W-1:0] best;
    logic                             launch;

    //////////////////////////////
    // queue selection
    //////////////////////////////

    always_comb begin
        pick_valid = 1'b0;
        pick_core  = '0;
        best       = '1;
        if (sched_mode == memoredf_pkg::TDMA) begin
            // slot owner only, idle slot if its queue is empty
            pick_valid = !empty[slot_owner];
            pick_core  = slot_owner;
        end else begin
            // smallest counter wins, strict < keeps the lowest index on ties
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (!empty[i] && (!pick_valid || (deadline_count[i] < best))) begin
                    pick_valid = 1'b1;
                    pick_core  = ID_W'(i);
                    best       = deadline_count[i];
                end
            end
        end
    end

    assign launch = (state == S_IDLE) && pick_valid;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:          if (pick_valid) state_next = S_ISSUE;
            S_ISSUE:         state_next = S_WAIT_CONSUMED;
            S_WAIT_CONSUMED: if (pkt_consumed) state_next = S_IDLE;
            default:         state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_IDLE;
            issue_valid <= 1'b0;
            issue_core  <= '0;
        end else begin
            state       <= state_next;
            issue_valid <= launch;
            if (launch) begin
                issue_core <= pick_core;
            end
        end
    end

    // head packet registered toward the serializer
    always_ff @(posedge aclk) begin
        if (launch) begin
            issue_data <= head_data[pick_core];
        end
    end

    // pop and reload in the issue cycle
    assign pop         = (state == S_ISSUE);
    assign pop_core    = issue_core;
    assign served      = (state == S_ISSUE);
    assign served_core = issue_core;

    // one packet in flight
    a_issue_single: assert property (
        @(posedge aclk) disable iff (!arst_n) issue_valid |=> !issue_valid);

    // serializer answers only an outstanding issue
    a_consumed_in_wait: assert property (
        @(posedge aclk) disable iff (!arst_n) pkt_consumed |-> state == S_WAIT_CONSUMED);

endmodule

// File: design/deadline_timers.sv
`timescale 1ns/1ps

module deadline_timers #(
    parameter  int NUM_QUEUES = 4,
    localparam int ID_W       = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
    input  logic                                              aclk,
    input  logic                                              arst_n,
    input  memoredf_pkg::sched_mode_e                         sched_mode,
    input  logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0]  periods,
    input  logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0]  deadlines,
    input  logic [NUM_QUEUES-1:0]                             cfg_deadline_we,
    input  logic                                              cfg_mode_we,
    input  logic                                              served,
    input  logic [ID_W-1:0]                                   served_core,
    output logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0]  deadline_count,
    output logic [ID_W-1:0]                                   slot_owner
);

    logic [memoredf_pkg::TIMER_W-1:0] slot_count;
    logic                             slot_end;

    //////////////////////////////
    // edf countdown
    //////////////////////////////

    // reload on service or on a deadline write
    // otherwise count down and hold at zero
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            deadline_count <= '0;
        end else begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (cfg_deadline_we[i] || (served && (served_core == ID_W'(i)))) begin
                    deadline_count[i] <= deadlines[i];
                end else if (deadline_count[i] != '0) begin
                    deadline_count[i] <= deadline_count[i] - 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // tdma slot rotation
    //////////////////////////////

    // >= so a shortened period still ends the slot
    assign slot_end = (slot_count >= periods[slot_owner]);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            slot_count <= '0;
            slot_owner <= '0;
        end else if (cfg_mode_we) begin
            // mode change restarts the frame at queue 0
            slot_count <= '0;
            slot_owner <= '0;
        end else if (sched_mode == memoredf_pkg::TDMA) begin
            if (slot_end) begin
                slot_count <= '0;
                // advance owner and wrap after the last queue
                if (slot_owner == ID_W'(NUM_QUEUES - 1)) begin
                    slot_owner <= '0;
                end else begin
                    slot_owner <= slot_owner + 1'b1;
                end
            end else begin
                slot_count <= slot_count + 1'b1;
            end
        end
    end

    // owner indexes periods and the empty flags in issue_fsm
    a_owner_in_range: assert property (
        @(posedge aclk) disable iff (!arst_n) int'(slot_owner) < NUM_QUEUES);

endmodule

// File: design/core_queues.sv
`timescale 1ns/1ps

module core_queues #(
    parameter  int NUM_QUEUES  = 4,
    parameter  int QUEUE_DEPTH = 8,
    parameter  int DATA_WIDTH  = 32,
    localparam int ID_W        = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
    input  logic                                 aclk,
    input  logic                                 arst_n,
    input  logic                                 pkt_valid,
    input  logic [ID_W-1:0]                      pkt_core,
    input  logic [DATA_WIDTH-1:0]                pkt_data,
    input  logic                                 pop,
    input  logic [ID_W-1:0]                      pop_core,
    output logic [NUM_QUEUES-1:0][DATA_WIDTH-1:0] head_data,
    output logic [NUM_QUEUES-1:0]                empty,
    output logic                                 stall
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [DATA_WIDTH-1:0]            mem [NUM_QUEUES][QUEUE_DEPTH];
    logic [NUM_QUEUES-1:0][PTR_W-1:0] rd_ptr;
    logic [NUM_QUEUES-1:0][PTR_W-1:0] wr_ptr;
    logic [NUM_QUEUES-1:0][CNT_W-1:0] count;
    logic [NUM_QUEUES-1:0][CNT_W-1:0] count_next;
    logic [NUM_QUEUES-1:0]            push_sel;
    logic [NUM_QUEUES-1:0]            pop_sel;
    logic                             stall_next;

    // circular pointer step, wraps at depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////
    // per-core occupancy
    //////////////////////////////

    always_comb begin
        stall_next = 1'b0;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            // pushes during stall are dropped
            push_sel[i]   = pkt_valid && !stall && (pkt_core == ID_W'(i));
            pop_sel[i]    = pop && (pop_core == ID_W'(i)) && (count[i] != '0);
            count_next[i] = count[i] + CNT_W'(push_sel[i]) - CNT_W'(pop_sel[i]);
            // stall tracks next occupancy so it rises right after the filling push
            stall_next    = stall_next || (count_next[i] == CNT_W'(QUEUE_DEPTH));
            empty[i]      = (count[i] == '0);
            // head is the oldest entry
            head_data[i]  = mem[i][rd_ptr[i]];
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            stall  <= 1'b0;
        end else begin
            count <= count_next;
            stall <= stall_next;
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (push_sel[i]) begin
                    wr_ptr[i] <= next_ptr(wr_ptr[i]);
                end
                if (pop_sel[i]) begin
                    rd_ptr[i] <= next_ptr(rd_ptr[i]);
                end
            end
        end
    end

    // packet storage
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NUM_QUEUES; i++) begin
            if (push_sel[i]) begin
                mem[i][wr_ptr[i]] <= pkt_data;
            end
        end
    end

    // source has to honour stall
    a_no_push_in_stall: assert property (
        @(posedge aclk) disable iff (!arst_n) pkt_valid |-> !stall);

    // scheduler only pops a queue it saw as non-empty
    a_no_pop_empty: assert property (
        @(posedge aclk) disable iff (!arst_n) pop |-> !empty[pop_core]);

endmodule

// File: design/config_regs.sv
`timescale 1ns/1ps

module config_regs #(
    parameter int NUM_QUEUES = 4
) (
    input  logic                                              aclk,
    input  logic                                              arst_n,
    input  logic                                              cfg_valid,
    input  logic [memoredf_pkg::CFG_ADDR_W-1:0]               cfg_addr,
    input  memoredf_pkg::cfg_word_u                           cfg_data,
    output memoredf_pkg::sched_mode_e                         sched_mode,
    output logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0]  periods,
    output logic [NUM_QUEUES-1:0][memoredf_pkg::TIMER_W-1:0]  deadlines,
    output logic [NUM_QUEUES-1:0]                             cfg_deadline_we,
    output logic                                              cfg_mode_we
);

    localparam int AW = memoredf_pkg::CFG_ADDR_W;

    logic                  mode_hit;
    logic [NUM_QUEUES-1:0] period_hit;
    logic [NUM_QUEUES-1:0] deadline_hit;

    // address decode
    // unmapped addresses hit nothing
    always_comb begin
        mode_hit = cfg_valid && (cfg_addr == memoredf_pkg::CFG_ADDR_MODE);
        for (int i = 0; i < NUM_QUEUES; i++) begin
            period_hit[i] = cfg_valid
                && (cfg_addr == memoredf_pkg::CFG_ADDR_PERIOD_BASE + AW'(i));
            deadline_hit[i] = cfg_valid
                && (cfg_addr == memoredf_pkg::CFG_ADDR_DEADLINE_BASE + AW'(i));
        end
    end

    //////////////////////////////
    // register file
    //////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            sched_mode      <= memoredf_pkg::EDF;
            periods         <= '0;
            deadlines       <= '0;
            cfg_deadline_we <= '0;
            cfg_mode_we     <= 1'b0;
        end else begin
            // strobes last a single cycle
            cfg_mode_we     <= mode_hit;
            cfg_deadline_we <= deadline_hit;
            // mode word takes bit 0 only
            if (mode_hit) begin
                sched_mode <= cfg_data.mode_view.mode;
            end
            for (int i = 0; i < NUM_QUEUES; i++) begin
                if (period_hit[i]) begin
                    periods[i] <= cfg_data.timer_view.value;
                end
                if (deadline_hit[i]) begin
                    deadlines[i] <= cfg_data.timer_view.value;
                end
            end
        end
    end

endmodule

// File: design/memoredf_pkg.sv
package memoredf_pkg;

    //////////////////////////////
    // scheduling modes
    //////////////////////////////

    // one bit, edf after reset
    typedef enum logic {
        EDF  = 1'b0,
        TDMA = 1'b1
    } sched_mode_e;

    //////////////////////////////
    // widths
    //////////////////////////////

    // periods, deadlines and all counters
    localparam int TIMER_W    = 16;
    localparam int CFG_DATA_W = 32;
    localparam int CFG_ADDR_W = 4;

    //////////////////////////////
    // configuration address map
    //////////////////////////////

    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MODE          = 4'h0;
    // queue i sits at base + i
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_PERIOD_BASE   = 4'h4;
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_DEADLINE_BASE = 4'h8;

    // timer view of a config word
    typedef struct packed {
        logic [CFG_DATA_W-TIMER_W-1:0] pad;
        logic [TIMER_W-1:0]            value;
    } cfg_timer_t;

    // mode view of a config word
    typedef struct packed {
        logic [CFG_DATA_W-2:0] pad;
        sched_mode_e           mode;
    } cfg_mode_t;

    // same 32 bits, decoded by address
    typedef union packed {
        cfg_timer_t timer_view;
        cfg_mode_t  mode_view;
    } cfg_word_u;

endpackage
